/* agnus_bus_pkg.sv */
// chip bus address types, DMA channel and CPU bus structs, bus owner enum
`default_nettype none

package agnus_bus_pkg;

  // --------------------
  // address types

  typedef logic [20:1] chip_addr_t;   // chip memory word address
  typedef logic [7:0]  reg_addr_t;    // custom register word address (byte addr 8:1)

  // no register selected on the register address bus
  localparam reg_addr_t REG_ADDR_IDLE = 8'hFF;

  // --------------------
  // one DMA engine as seen by the bus

  typedef struct packed {
    logic       req;          // level, held while the engine wants a slot
    logic       write;        // memory write, disk and blitter only
    chip_addr_t address;      // chip memory pointer
    reg_addr_t  reg_address;  // destination or source register
  } dma_chan_t;

  // CPU side of the register bank
  typedef struct packed {
    logic      aen;      // register bank address enable
    logic      rd;       // read strobe
    logic      hwr;      // high byte write
    logic      lwr;      // low byte write
    reg_addr_t address;  // register word address
  } cpu_bus_t;

  // slot owner, listed from highest to lowest priority
  typedef enum logic [2:0] {
    OWN_DSK,
    OWN_REF,
    OWN_AUD,
    OWN_BPL,
    OWN_SPR,
    OWN_COP,
    OWN_BLT,
    OWN_CPU
  } bus_owner_e;

endpackage

`default_nettype wire

/* agnus_regs_pkg.sv */
// register address enum, DMACON bit layout and gated DMA enable struct
`default_nettype none

package agnus_regs_pkg;

  // --------------------
  // register word addresses (byte address >> 1)

  typedef enum logic [7:0] {
    DMACONR = 8'h01,  // byte 0x002, read only
    DMACON  = 8'h4B   // byte 0x096, write only, set/clear
  } reg_name_e;

  // --------------------
  // writable part of DMACON, bits 12:0
  // bit 15 of a write selects set or clear and is not stored
  // bits 14:13 read back blitter busy and zero, see DMACONR

  typedef struct packed {
    logic [1:0] spare_hi;  // 12:11, unused but stored
    logic       bltpri;    // 10 blitter nasty
    logic       dmaen;     // 9 master enable
    logic       bplen;     // 8 bitplanes
    logic       copen;     // 7 copper
    logic       blten;     // 6 blitter
    logic       spren;     // 5 sprites
    logic [4:0] spare_lo;  // 4:0 disk and audio, read back only here
  } dmacon_t;

  // --------------------
  // enables handed to the arbiter
  // each channel enable is already qualified by dmaen

  typedef struct packed {
    logic bpl;     // bitplane
    logic cop;     // copper
    logic blt;     // blitter
    logic spr;     // sprite
    logic bltpri;  // blitter nasty, not gated
  } dma_enables_t;

endpackage

`default_nettype wire

/* beam_counter.sv */
// horizontal beam counter with colour clock phase, refresh slots, sol and strobes
`timescale 1ns/1ps
`default_nettype none

module beam_counter #(
  parameter int unsigned LINE_LENGTH = 454  // hpos counts per line
) (
  input  wire        clk,
  input  wire        reset,
  input  wire        clk7_en,        // bus clock enable
  output logic [8:0] hpos,           // horizontal position
  output logic       cck,            // colour clock phase, odd slots
  output logic       dma_ref,        // memory refresh slot
  output logic       sol,            // last position of the line
  output logic       strhor_denise,  // horizontal strobe for Denise
  output logic       strhor_paula    // horizontal strobe for Paula
);

  localparam logic [8:0] HPOS_LAST    = 9'(LINE_LENGTH - 1);
  localparam logic [8:0] HPOS_DENISE  = 9'd11;  // one cck ahead of Paula
  localparam logic [8:0] HPOS_PAULA   = 9'd13;

  // --------------------
  // counter

  always_ff @(posedge clk) begin
    if (clk7_en) begin
      if (reset) begin
        hpos <= '0;
      end else if (sol) begin
        hpos <= '0;               // wrap at end of line
      end else begin
        hpos <= hpos + 9'd1;
      end
    end
  end

  // --------------------
  // decodes

  assign cck = hpos[0];           // chipset uses odd slots

  // refresh takes slots 1, 5, 9 and 13
  // all are below 16 and have 01 in the low two bits
  assign dma_ref = (hpos[8:4] == 5'd0) && (hpos[1:0] == 2'b01);

  assign sol = (hpos == HPOS_LAST);

  // strobes depend on hpos only, no vertical condition
  assign strhor_denise = (hpos == HPOS_DENISE);
  assign strhor_paula  = (hpos == HPOS_PAULA);

endmodule

`default_nettype wire

/* dma_control_regs.sv */
// DMACON register with set/clear write, DMACONR read data and gated channel enables
`timescale 1ns/1ps
`default_nettype none

module dma_control_regs
  import agnus_bus_pkg::*;
  import agnus_regs_pkg::*;
(
  input  wire               clk,
  input  wire               reset,
  input  wire               clk7_en,      // bus clock enable
  input  wire reg_addr_t    reg_address,  // register bus as the arbiter selected it
  input  wire        [15:0] data_in,      // data bus from CPU or DMA
  input  wire               blit_busy,    // blitter status for read-back
  input  wire               blit_zero,
  input  wire        [15:0] blt_data,     // blitter register read data
  output dma_enables_t      enables,      // to the arbiter
  output logic       [15:0] data_out      // merged read data
);

  dmacon_t     dmacon;      // stored bits 12:0
  logic        dmacon_wr;   // DMACON selected this slot
  logic        dmaconr_rd;  // DMACONR selected this slot
  logic [12:0] dmacon_set;  // value after a set write
  logic [12:0] dmacon_clr;  // value after a clear write
  logic [15:0] dmaconr;     // read data, zero when not addressed

  // --------------------
  // address decode

  assign dmacon_wr  = (reg_address == DMACON);
  assign dmaconr_rd = (reg_address == DMACONR);

  // --------------------
  // write, bit 15 picks set or clear for every 1 in 12:0

  assign dmacon_set = dmacon | data_in[12:0];
  assign dmacon_clr = dmacon & ~data_in[12:0];

  always_ff @(posedge clk) begin
    if (clk7_en) begin
      if (reset) begin
        dmacon <= '0;                 // all DMA off
      end else if (dmacon_wr) begin
        if (data_in[15]) begin
          dmacon <= dmacon_set;
        end else begin
          dmacon <= dmacon_clr;
        end
      end
    end
  end

  // --------------------
  // read, bit 15 reads 0, then busy, zero and the stored bits

  always_comb begin
    if (dmaconr_rd) begin
      dmaconr = {1'b0, blit_busy, blit_zero, dmacon};
    end else begin
      dmaconr = '0;
    end
  end

  // only one source drives at a time, so a plain OR merges them
  assign data_out = dmaconr | blt_data;

  // --------------------
  // enables, master bit gates each channel

  assign enables.bpl    = dmacon.bplen & dmacon.dmaen;
  assign enables.cop    = dmacon.copen & dmacon.dmaen;
  assign enables.blt    = dmacon.blten & dmacon.dmaen;
  assign enables.spr    = dmacon.spren & dmacon.dmaen;
  assign enables.bltpri = dmacon.bltpri;  // nasty works without dmaen

endmodule

`default_nettype wire

/* bus_arbiter.sv */
// chip bus priority arbiter, grants, CPU register decode and blitter slowdown counter
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter
  import agnus_bus_pkg::*;
  import agnus_regs_pkg::*;
#(
  parameter logic [1:0] BLS_CNT_MAX = 2'd3  // missed CPU cycles before blitter hold-off
) (
  input  wire               clk,
  input  wire               reset,
  input  wire               clk7_en,      // bus clock enable
  input  wire               cck,          // colour clock phase
  input  wire               turbo,        // blitter may take even slots too
  input  wire               bls,          // CPU is waiting for the bus
  input  wire               dma_ref,      // refresh slot
  input  wire dma_enables_t enables,      // from DMACON
  input  wire cpu_bus_t     cpu,
  input  wire dma_chan_t    dsk_chan,
  input  wire dma_chan_t    aud_chan,
  input  wire dma_chan_t    bpl_chan,
  input  wire dma_chan_t    spr_chan,
  input  wire dma_chan_t    cop_chan,
  input  wire dma_chan_t    blt_chan,
  output reg_addr_t         reg_address,  // selected register address
  output chip_addr_t        address_out,  // selected chip address
  output logic              dbr,          // Agnus owns the data bus
  output logic              dbwe,         // memory write this slot
  output logic              cpu_custom,   // CPU owns the slot
  output logic              ack_spr,
  output logic              ack_cop,
  output logic              ack_blt,
  output logic              ena_cop,      // copper may run
  output logic              ena_blt       // blitter may run
);

  bus_owner_e owner;            // winner of this slot
  logic [1:0] bls_cnt;          // memory cycles the CPU has missed
  logic       bls_ok;           // blitter not held off
  logic       dma_spr;          // requests qualified by enables
  logic       dma_cop;
  logic       dma_blt;
  logic       cpu_access;       // valid CPU register cycle
  reg_addr_t  reg_address_cpu;

  // --------------------
  // request qualification

  assign dma_spr = spr_chan.req & enables.spr;
  assign dma_cop = cop_chan.req & enables.cop;
  assign dma_blt = blt_chan.req & enables.blt;
  assign bls_ok  = (bls_cnt < BLS_CNT_MAX);

  // CPU address passes only during a real access
  assign cpu_access      = cpu.aen & (cpu.rd | cpu.hwr | cpu.lwr);
  assign reg_address_cpu = cpu_access ? cpu.address : REG_ADDR_IDLE;

  // --------------------
  // fixed priority, first match wins

  always_comb begin
    if (dsk_chan.req) begin
      owner = OWN_DSK;
    end else if (dma_ref) begin
      owner = OWN_REF;
    end else if (aud_chan.req) begin
      owner = OWN_AUD;
    end else if (bpl_chan.req) begin
      owner = OWN_BPL;
    end else if (dma_spr) begin
      owner = OWN_SPR;
    end else if (dma_cop) begin
      owner = OWN_COP;
    end else if (dma_blt && bls_ok) begin
      owner = OWN_BLT;
    end else begin
      owner = OWN_CPU;              // bus left free for the CPU
    end
  end

  // --------------------
  // output multiplexer

  always_comb begin
    dbr         = 1'b1;            // any chipset owner takes the bus
    cpu_custom  = 1'b0;
    dbwe        = 1'b0;
    ack_spr     = 1'b0;
    ack_cop     = 1'b0;
    ack_blt     = 1'b0;
    address_out = '0;
    reg_address = REG_ADDR_IDLE;
    case (owner)
      OWN_DSK: begin
        address_out = dsk_chan.address;
        reg_address = dsk_chan.reg_address;
        dbwe        = dsk_chan.write;  // disk reads from memory on write-out
      end
      OWN_REF: begin
        // refresh only, no address and no register
      end
      OWN_AUD: begin
        address_out = aud_chan.address;
        reg_address = aud_chan.reg_address;
      end
      OWN_BPL: begin
        address_out = bpl_chan.address;
        reg_address = bpl_chan.reg_address;
      end
      OWN_SPR: begin
        address_out = spr_chan.address;
        reg_address = spr_chan.reg_address;
        ack_spr     = 1'b1;
      end
      OWN_COP: begin
        address_out = cop_chan.address;
        reg_address = cop_chan.reg_address;
        ack_cop     = 1'b1;
      end
      OWN_BLT: begin
        address_out = blt_chan.address;
        reg_address = blt_chan.reg_address;
        dbwe        = blt_chan.write;
        ack_blt     = 1'b1;
      end
      default: begin                // OWN_CPU
        dbr         = 1'b0;
        cpu_custom  = 1'b1;
        reg_address = reg_address_cpu;
      end
    endcase
  end

  // --------------------
  // run enables for copper and blitter

  // copper shares its slots only with bitplanes
  assign ena_cop = ~bpl_chan.req;

  // blitter is last in line, anything above it blocks it
  assign ena_blt = ~(dsk_chan.req | dma_ref | aud_chan.req | dma_spr |
                     bpl_chan.req | dma_cop) & enables.blt & bls_ok;

  // --------------------
  // blitter slowdown, counts on memory cycles only

  always_ff @(posedge clk) begin
    if (clk7_en) begin
      if (reset) begin
        bls_cnt <= '0;
      end else if (!cck || turbo) begin
        if (!bls || enables.bltpri) begin
          bls_cnt <= '0;            // CPU got in, or nasty mode
        end else if (bls_cnt != BLS_CNT_MAX) begin
          bls_cnt <= bls_cnt + 2'd1;  // saturates at max
        end
      end
    end
  end

endmodule

`default_nettype wire

/* agnus_top.sv */
// Agnus bus side top level with beam counter, DMA control register and arbiter
`timescale 1ns/1ps
`default_nettype none

module agnus_top
  import agnus_bus_pkg::*;
  import agnus_regs_pkg::*;
#(
  parameter int unsigned LINE_LENGTH = 454,   // hpos counts per line
  parameter logic [1:0]  BLS_CNT_MAX = 2'd3   // blitter slowdown limit
) (
  input  wire               clk,
  input  wire               reset,
  input  wire               clk7_en,          // bus clock enable
  // DMA engines
  input  wire dma_chan_t    dsk_chan,
  input  wire dma_chan_t    aud_chan,
  input  wire dma_chan_t    bpl_chan,
  input  wire dma_chan_t    spr_chan,
  input  wire dma_chan_t    cop_chan,
  input  wire dma_chan_t    blt_chan,
  // CPU and data
  input  wire cpu_bus_t     cpu,
  input  wire        [15:0] data_in,
  input  wire        [15:0] blt_data,         // blitter register read data
  input  wire               blit_busy,
  input  wire               blit_zero,
  input  wire               bls,              // blitter slowdown request
  input  wire               turbo,
  // chip bus
  output chip_addr_t        address_out,
  output reg_addr_t         reg_address_out,
  output wire               dbr,
  output wire               dbwe,
  output wire               cpu_custom,
  // grants
  output wire               ack_spr,
  output wire               ack_cop,
  output wire               ack_blt,
  output wire               ena_cop,
  output wire               ena_blt,
  output wire        [15:0] data_out,
  // beam
  output wire         [8:0] hpos,
  output wire               sol,
  output wire               strhor_denise,
  output wire               strhor_paula
);

  wire          cck;       // colour clock phase
  wire          dma_ref;   // refresh slot
  dma_enables_t enables;   // DMACON to arbiter

  // --------------------
  beam_counter #(
    .LINE_LENGTH   (LINE_LENGTH)
  ) beam_i (
    .clk           (clk),
    .reset         (reset),
    .clk7_en       (clk7_en),
    .hpos          (hpos),
    .cck           (cck),
    .dma_ref       (dma_ref),
    .sol           (sol),
    .strhor_denise (strhor_denise),
    .strhor_paula  (strhor_paula)
  );

  // --------------------
  // register block sees the arbiter's register bus
  dma_control_regs regs_i (
    .clk         (clk),
    .reset       (reset),
    .clk7_en     (clk7_en),
    .reg_address (reg_address_out),
    .data_in     (data_in),
    .blit_busy   (blit_busy),
    .blit_zero   (blit_zero),
    .blt_data    (blt_data),
    .enables     (enables),
    .data_out    (data_out)
  );

  // --------------------
  bus_arbiter #(
    .BLS_CNT_MAX (BLS_CNT_MAX)
  ) arb_i (
    .clk         (clk),
    .reset       (reset),
    .clk7_en     (clk7_en),
    .cck         (cck),
    .turbo       (turbo),
    .bls         (bls),
    .dma_ref     (dma_ref),
    .enables     (enables),
    .cpu         (cpu),
    .dsk_chan    (dsk_chan),
    .aud_chan    (aud_chan),
    .bpl_chan    (bpl_chan),
    .spr_chan    (spr_chan),
    .cop_chan    (cop_chan),
    .blt_chan    (blt_chan),
    .reg_address (reg_address_out),
    .address_out (address_out),
    .dbr         (dbr),
    .dbwe        (dbwe),
    .cpu_custom  (cpu_custom),
    .ack_spr     (ack_spr),
    .ack_cop     (ack_cop),
    .ack_blt     (ack_blt),
    .ena_cop     (ena_cop),
    .ena_blt     (ena_blt)
  );

endmodule

`default_nettype wire

/* tb_agnus_top.sv */
// testbench for agnus_top with clock, reset, random stimulus, reference model and assertions
`timescale 1ns/1ps
`default_nettype none

module tb_agnus_top
  import agnus_bus_pkg::*;
  import agnus_regs_pkg::*;
();

  localparam logic [8:0] HPOS_LAST   = 9'd453;  // default line length minus one
  localparam int         BLS_CNT_MAX = 3;       // default slowdown limit

  logic        clk;
  logic        reset;
  logic        clk7_en;
  dma_chan_t   dsk_chan, aud_chan, bpl_chan, spr_chan, cop_chan, blt_chan;
  cpu_bus_t    cpu;
  logic [15:0] data_in;
  logic [15:0] blt_data;
  logic        blit_busy, blit_zero, bls, turbo;
  chip_addr_t  address_out;
  reg_addr_t   reg_address_out;
  logic        dbr, dbwe, cpu_custom;
  logic        ack_spr, ack_cop, ack_blt, ena_cop, ena_blt;
  logic [15:0] data_out;
  logic [8:0]  hpos;
  logic        sol, strhor_denise, strhor_paula;

  // reference model state, advanced at each falling edge for the coming rising edge
  logic [8:0]  m_hpos;
  dmacon_t     m_dmacon;
  int          m_bls_cnt;
  bit          checking;   // DUT is out of reset

  agnus_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  // --------------------
  // helpers

  function automatic logic ref_slot(input logic [8:0] h);
    return (h == 9'd1) || (h == 9'd5) || (h == 9'd9) || (h == 9'd13);
  endfunction

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Checks failed");
      $display("error %s got %h expected %h", name, got, exp);
      $fatal(1);
    end
  endtask

  function automatic dma_chan_t random_chan(input int unsigned pct);
    dma_chan_t ch;
    ch.req         = ($urandom % 100) < pct;
    ch.write       = 1'($urandom);
    ch.address     = 20'($urandom);
    ch.reg_address = 8'($urandom);
    return ch;
  endfunction

  function automatic cpu_bus_t random_cpu();
    cpu_bus_t    c;
    int unsigned pick;
    pick  = $urandom % 4;
    c.aen = ($urandom % 4) != 0;
    c.rd  = 1'($urandom);
    c.hwr = 1'($urandom);
    c.lwr = 1'($urandom);
    if (pick == 0) c.address = DMACON;       // random set/clear writes
    else if (pick == 1) c.address = DMACONR;
    else c.address = 8'($urandom);
    return c;
  endfunction

  // --------------------
  // stimulus tasks, all inputs change on the rising edge

  task automatic apply_reset();
    reset <= 1'b1;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
  endtask

  task automatic drive_random();
    @(posedge clk);
    clk7_en   <= ($urandom % 4) != 0;  // gaps in the bus clock
    dsk_chan  <= random_chan(6);
    aud_chan  <= random_chan(6);
    bpl_chan  <= random_chan(12);
    spr_chan  <= random_chan(30);
    cop_chan  <= random_chan(30);
    blt_chan  <= random_chan(40);
    cpu       <= random_cpu();
    data_in   <= 16'($urandom);
    blt_data  <= (($urandom % 2) != 0) ? 16'($urandom) : 16'h0;
    blit_busy <= 1'($urandom);
    blit_zero <= 1'($urandom);
    bls       <= ($urandom % 4) != 0;
    turbo     <= ($urandom % 8) == 0;
  endtask

  task automatic idle_all();
    @(posedge clk);
    clk7_en   <= 1'b1;
    {dsk_chan, aud_chan, bpl_chan} <= '0;
    {spr_chan, cop_chan, blt_chan} <= '0;
    cpu       <= '0;
    data_in   <= 16'h0;
    blt_data  <= 16'h0;
    {blit_busy, blit_zero, bls, turbo} <= 4'b0;
  endtask

  // sprite, copper and blitter ask for the bus while DMACON may mask them
  task automatic raise_chan_reqs();
    @(posedge clk);
    spr_chan.req <= 1'b1;
    cop_chan.req <= 1'b1;
    blt_chan.req <= 1'b1;
  endtask

  // two cycles, so one refresh slot cannot swallow the write
  task automatic write_reg(input reg_addr_t addr, input logic [15:0] val);
    @(posedge clk);
    cpu     <= '{aen: 1'b1, rd: 1'b0, hwr: 1'b1, lwr: 1'b1, address: addr};
    data_in <= val;
    repeat (2) @(posedge clk);
    cpu     <= '0;
  endtask

  task automatic read_dmaconr(input logic [15:0] bdata);
    @(posedge clk);
    cpu       <= '{aen: 1'b1, rd: 1'b1, hwr: 1'b0, lwr: 1'b0, address: DMACONR};
    blt_data  <= bdata;
    blit_busy <= 1'b1;
    repeat (2) @(posedge clk);
    cpu       <= '0;
    blt_data  <= 16'h0;
  endtask

  task automatic drive_blitter(input logic req, input logic slow);
    @(posedge clk);
    blt_chan <= '{req: req, write: 1'b1, address: 20'h4A5C3, reg_address: 8'h30};
    bls      <= slow;   // CPU waiting
  endtask

  task automatic wait_ack_blt(input logic level, input int limit);
    int n;
    bit done;
    n    = 0;
    done = 1'b0;
    while (!done && n < limit) begin
      @(negedge clk);
      done = (ack_blt === level) && !(level == 1'b0 && ref_slot(hpos));  // skip refresh
      n++;
    end
    if (!done) begin
      $display("Checks failed");
      $display("timeout waiting for ack_blt to become %0d after %0d cycles", level, limit);
      $fatal(1);
    end
  endtask

  task automatic check_cpu_only(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      if (!ref_slot(hpos)) begin
        check_val("cpu_custom", 32'(cpu_custom), 32'd1);
        check_val("dbr", 32'(dbr), 32'd0);
        check_val("acks", 32'({ack_spr, ack_cop, ack_blt}), 32'd0);
      end
    end
  endtask

  // --------------------
  // reference model and per-cycle checks

  always @(negedge clk) begin : model
    bus_owner_e  own;
    dma_chan_t   ch;
    logic        is_ref, spr_ok, cop_ok, blt_ok, bls_ok;
    reg_addr_t   e_reg;
    logic        e_we;
    logic        e_ena_blt;
    logic [15:0] e_data;

    is_ref = ref_slot(m_hpos);
    spr_ok = spr_chan.req && m_dmacon.spren && m_dmacon.dmaen;
    cop_ok = cop_chan.req && m_dmacon.copen && m_dmacon.dmaen;
    bls_ok = m_bls_cnt < BLS_CNT_MAX;
    blt_ok = blt_chan.req && m_dmacon.blten && m_dmacon.dmaen && bls_ok;

    if (dsk_chan.req) own = OWN_DSK;
    else if (is_ref) own = OWN_REF;
    else if (aud_chan.req) own = OWN_AUD;
    else if (bpl_chan.req) own = OWN_BPL;
    else if (spr_ok) own = OWN_SPR;
    else if (cop_ok) own = OWN_COP;
    else if (blt_ok) own = OWN_BLT;
    else own = OWN_CPU;

    case (own)
      OWN_DSK: ch = dsk_chan;
      OWN_AUD: ch = aud_chan;
      OWN_BPL: ch = bpl_chan;
      OWN_SPR: ch = spr_chan;
      OWN_COP: ch = cop_chan;
      OWN_BLT: ch = blt_chan;
      default: ch = '0;         // refresh and CPU drive no chip address
    endcase
    e_reg = (own == OWN_REF) ? REG_ADDR_IDLE : ch.reg_address;
    if (own == OWN_CPU) begin
      e_reg = (cpu.aen && (cpu.rd || cpu.hwr || cpu.lwr)) ? cpu.address : REG_ADDR_IDLE;
    end
    e_we      = (own == OWN_DSK || own == OWN_BLT) ? ch.write : 1'b0;
    e_data    = (e_reg == DMACONR) ? {1'b0, blit_busy, blit_zero, m_dmacon} : 16'h0;
    e_data    = e_data | blt_data;
    e_ena_blt = !(dsk_chan.req || is_ref || aud_chan.req || spr_ok || bpl_chan.req || cop_ok)
                && m_dmacon.blten && m_dmacon.dmaen && bls_ok;

    if (checking) begin
      check_val("hpos", 32'(hpos), 32'(m_hpos));
      check_val("sol", 32'(sol), 32'(m_hpos == HPOS_LAST));
      check_val("strhor_denise", 32'(strhor_denise), 32'(m_hpos == 9'd11));
      check_val("strhor_paula", 32'(strhor_paula), 32'(m_hpos == 9'd13));
      check_val("address_out", 32'(address_out), 32'(ch.address));
      check_val("reg_address_out", 32'(reg_address_out), 32'(e_reg));
      check_val("dbr", 32'(dbr), 32'(own != OWN_CPU));
      check_val("dbwe", 32'(dbwe), 32'(e_we));
      check_val("cpu_custom", 32'(cpu_custom), 32'(own == OWN_CPU));
      check_val("ack_spr", 32'(ack_spr), 32'(own == OWN_SPR));
      check_val("ack_cop", 32'(ack_cop), 32'(own == OWN_COP));
      check_val("ack_blt", 32'(ack_blt), 32'(own == OWN_BLT));
      check_val("ena_cop", 32'(ena_cop), 32'(!bpl_chan.req));
      check_val("ena_blt", 32'(ena_blt), 32'(e_ena_blt));
      check_val("data_out", 32'(data_out), 32'(e_data));
    end

    // next state, as the DUT takes it on the coming rising edge
    if (clk7_en) begin
      if (reset) begin
        m_hpos    = 9'd0;
        m_dmacon  = '0;
        m_bls_cnt = 0;
      end else begin
        if (!m_hpos[0] || turbo) begin      // memory cycle or turbo
          if (!bls || m_dmacon.bltpri) m_bls_cnt = 0;
          else if (m_bls_cnt < BLS_CNT_MAX) m_bls_cnt++;
        end
        if (e_reg == DMACON) begin
          m_dmacon = data_in[15] ? (m_dmacon | data_in[12:0]) : (m_dmacon & ~data_in[12:0]);
        end
        m_hpos = (m_hpos == HPOS_LAST) ? 9'd0 : m_hpos + 9'd1;
      end
    end
  end

  // --------------------
  // test sequence

  initial begin
    void'($urandom(32'h3320));
    checking  = 1'b0;
    reset     = 1'b1;
    clk7_en   = 1'b1;
    dsk_chan  = '0;
    aud_chan  = '0;
    bpl_chan  = '0;
    spr_chan  = '{req: 1'b1, write: 1'b0, address: 20'h00140, reg_address: 8'hA0};
    cop_chan  = '{req: 1'b1, write: 1'b0, address: 20'h02000, reg_address: 8'h44};
    blt_chan  = '{req: 1'b1, write: 1'b1, address: 20'h08000, reg_address: 8'h30};
    cpu       = '0;
    data_in   = 16'h0;
    blt_data  = 16'h0;
    blit_busy = 1'b0;
    blit_zero = 1'b0;
    bls       = 1'b0;
    turbo     = 1'b0;

    apply_reset();
    checking = 1'b1;
    check_cpu_only(20);             // DMACON clear, requests masked

    // set and clear through the CPU bus, then read back
    idle_all();
    write_reg(DMACON, 16'h9FFF);
    read_dmaconr(16'h0101);
    write_reg(DMACON, 16'h0AAA);
    read_dmaconr(16'h0);
    write_reg(DMACON, 16'h1FFF);
    raise_chan_reqs();
    check_cpu_only(4);              // cleared DMACON masks live requests

    repeat (3000) drive_random();   // priority, beam, decode

    // slowdown holds the blitter off
    idle_all();
    write_reg(DMACON, 16'h0400);    // bltpri off
    write_reg(DMACON, 16'h8240);    // dmaen and blten
    drive_blitter(1'b1, 1'b1);
    wait_ack_blt(1'b0, 40);
    drive_blitter(1'b1, 1'b0);      // CPU got the bus
    wait_ack_blt(1'b1, 40);

    // nasty mode never lets go
    drive_blitter(1'b0, 1'b0);
    write_reg(DMACON, 16'h8400);
    drive_blitter(1'b1, 1'b1);
    repeat (40) begin
      @(negedge clk);
      if (!ref_slot(hpos)) check_val("ack_blt", 32'(ack_blt), 32'd1);
    end

    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

/* agnus_dma.f */
agnus_bus_pkg.sv
agnus_regs_pkg.sv
beam_counter.sv
dma_control_regs.sv
bus_arbiter.sv
agnus_top.sv
tb_agnus_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the agnus_dma testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module tb_agnus_top -f agnus_dma.f \
  -o sim_agnus_dma > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_agnus_dma > sim.log 2>&1
cat sim.log
grep -q "Checks failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
